// File: cpu_pkg.sv
package cpu_pkg;

    localparam int DATA_WIDTH    = 8;  // Bus and register width
    localparam int ADDR_WIDTH    = 4;  // RAM address and PC width
    localparam int OPCODE_WIDTH  = 4;
    localparam int OPERAND_WIDTH = 4;
    localparam int RAM_DEPTH     = 16;
    localparam int STEP_WIDTH    = 3;  // Up to 8 microsteps per opcode

    // Instruction opcodes, high nibble of an instruction word
    localparam logic [OPCODE_WIDTH-1:0] OP_NOP  = 4'h0;
    localparam logic [OPCODE_WIDTH-1:0] OP_LDA  = 4'h1;
    localparam logic [OPCODE_WIDTH-1:0] OP_ADD  = 4'h2;
    localparam logic [OPCODE_WIDTH-1:0] OP_SUB  = 4'h3;
    localparam logic [OPCODE_WIDTH-1:0] OP_STA  = 4'h4;
    localparam logic [OPCODE_WIDTH-1:0] OP_LDI  = 4'h5;
    localparam logic [OPCODE_WIDTH-1:0] OP_JMP  = 4'h6;
    localparam logic [OPCODE_WIDTH-1:0] OP_JC   = 4'h7;
    localparam logic [OPCODE_WIDTH-1:0] OP_JZ   = 4'h8;
    localparam logic [OPCODE_WIDTH-1:0] OP_OUTA = 4'h9;
    localparam logic [OPCODE_WIDTH-1:0] OP_HLT  = 4'hF;

    localparam logic ALU_ADD = 1'b0;
    localparam logic ALU_SUB = 1'b1;  // A + ~B + 1

    // Sequencer states
    localparam logic [2:0] ST_RESET    = 3'd0;
    localparam logic [2:0] ST_FETCH_0  = 3'd1;
    localparam logic [2:0] ST_FETCH_1  = 3'd2;
    localparam logic [2:0] ST_DECODE_0 = 3'd3;
    localparam logic [2:0] ST_DECODE_1 = 3'd4;
    localparam logic [2:0] ST_WAIT     = 3'd5;  // IR settles before the ROM is read
    localparam logic [2:0] ST_EXECUTE  = 3'd6;
    localparam logic [2:0] ST_HALT     = 3'd7;

    // One RAM word, seen as an instruction or as plain data
    typedef union packed {
        struct packed {
            logic [OPCODE_WIDTH-1:0]  opcode;
            logic [OPERAND_WIDTH-1:0] operand;
        } instr;
        logic [DATA_WIDTH-1:0] data;
    } instr_word_u;

    localparam string PROGRAM_FILE = "program.hex";

endpackage

// File: program_counter.sv
`timescale 1ns/1ps

module program_counter import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  load_i,    // Jump target from the bus
    input  logic                  enable_i,  // Step to next instruction
    input  logic [ADDR_WIDTH-1:0] count_i,
    output logic [ADDR_WIDTH-1:0] count_o
);

    always_ff @(posedge clk) begin
        if (reset) begin
            count_o <= '0;
        end else if (load_i) begin
            count_o <= count_i;           // Load wins over increment
        end else if (enable_i) begin
            count_o <= count_o + 1'b1;    // Wraps at 16
        end
    end

    // Increment comes from decode, load from execute, so never together
    assert property (@(posedge clk) disable iff (reset) !(load_i && enable_i));

endmodule

// File: alu.sv
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [DATA_WIDTH-1:0] a_i,
    input  logic [DATA_WIDTH-1:0] b_i,
    input  logic                  op_i,      // ALU_ADD or ALU_SUB
    output logic [DATA_WIDTH-1:0] result_o,
    output logic                  carry_o,
    output logic                  zero_o
);

    logic [DATA_WIDTH:0] sum;  // Extra bit is the carry out

    always_comb begin
        if (op_i == ALU_SUB) begin
            sum = {1'b0, a_i} + {1'b0, ~b_i} + 1'b1;  // Carry set when A >= B
        end else begin
            sum = {1'b0, a_i} + {1'b0, b_i};
        end
    end

    // Registered every cycle, so a result is valid one step after B loads
    always_ff @(posedge clk) begin
        if (reset) begin
            result_o <= '0;
            carry_o  <= 1'b0;
            zero_o   <= 1'b0;
        end else begin
            result_o <= sum[DATA_WIDTH-1:0];
            carry_o  <= sum[DATA_WIDTH];
            zero_o   <= (sum[DATA_WIDTH-1:0] == '0);
        end
    end

endmodule

// File: ram.sv
`timescale 1ns/1ps

module ram import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  write_i,
    input  logic [ADDR_WIDTH-1:0] addr_i,   // From MAR
    input  logic [DATA_WIDTH-1:0] data_i,   // From the bus
    output logic [DATA_WIDTH-1:0] data_o
);

    logic [DATA_WIDTH-1:0] mem [RAM_DEPTH];

    // Program and data image
    initial begin
        $readmemh(PROGRAM_FILE, mem);
    end

    always_ff @(posedge clk) begin
        if (write_i) begin
            mem[addr_i] <= data_i;
        end
    end

    assign data_o = mem[addr_i];  // Asynchronous read

endmodule

// File: datapath.sv
`timescale 1ns/1ps

module datapath import cpu_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    load_a_i,
    input  logic                    load_b_i,
    input  logic                    load_o_i,
    input  logic                    load_ir_i,
    input  logic                    load_mar_i,
    input  logic                    load_ram_i,
    input  logic                    load_flags_i,
    input  logic                    load_sets_z_i,  // Zero flag taken from the bus
    input  logic                    oe_pc_i,
    input  logic                    oe_ram_i,
    input  logic                    oe_ir_i,
    input  logic                    oe_alu_i,
    input  logic                    oe_a_i,
    input  logic                    alu_op_i,
    input  logic [ADDR_WIDTH-1:0]   pc_i,
    output logic [ADDR_WIDTH-1:0]   bus_pc_o,       // Jump target for the PC
    output logic [OPCODE_WIDTH-1:0] opcode_o,
    output logic                    zero_o,
    output logic                    carry_o,
    output logic [DATA_WIDTH-1:0]   out_o,
    output logic                    out_strobe_o
);

    logic [DATA_WIDTH-1:0] bus;
    logic [DATA_WIDTH-1:0] a_q, b_q;
    logic [DATA_WIDTH-1:0] alu_result, ram_data;
    logic [ADDR_WIDTH-1:0] mar_q;
    instr_word_u           ir_q;
    logic                  alu_carry, alu_zero;
    logic                  zero_in;

    // Shared bus as a priority mux, PC highest
    assign bus = oe_pc_i  ? {{(DATA_WIDTH-ADDR_WIDTH){1'b0}}, pc_i} :
                 oe_ram_i ? ram_data :
                 oe_ir_i  ? {{(DATA_WIDTH-OPERAND_WIDTH){1'b0}}, ir_q.instr.operand} :
                 oe_alu_i ? alu_result :
                 oe_a_i   ? a_q :
                 '0;

    assign bus_pc_o = bus[ADDR_WIDTH-1:0];
    assign opcode_o = ir_q.instr.opcode;
    assign zero_in  = load_sets_z_i ? (bus == '0) : alu_zero;  // Loads test the bus

    always_ff @(posedge clk) begin
        if (reset) begin
            a_q          <= '0;
            b_q          <= '0;
            out_o        <= '0;
            out_strobe_o <= 1'b0;
            zero_o       <= 1'b0;
            carry_o      <= 1'b0;
        end else begin
            if (load_a_i) a_q <= bus;
            if (load_b_i) b_q <= bus;
            if (load_o_i) out_o <= bus;
            out_strobe_o <= load_o_i;      // Pulse alongside the new output
            if (load_flags_i) begin
                zero_o  <= zero_in;
                carry_o <= alu_carry;      // Carry always from the ALU
            end
        end
    end

    // Instruction and address registers
    always_ff @(posedge clk) begin
        if (load_ir_i) ir_q.data <= bus;
        if (load_mar_i) mar_q <= bus[ADDR_WIDTH-1:0];
    end

    alu u_alu (
        .clk      (clk),
        .reset    (reset),
        .a_i      (a_q),
        .b_i      (b_q),
        .op_i     (alu_op_i),
        .result_o (alu_result),
        .carry_o  (alu_carry),
        .zero_o   (alu_zero)
    );

    ram u_ram (
        .clk     (clk),
        .write_i (load_ram_i),
        .addr_i  (mar_q),
        .data_i  (bus),
        .data_o  (ram_data)
    );

    // Sequencer and ROM together must never enable two bus drivers
    assert property (@(posedge clk) disable iff (reset)
        $onehot0({oe_pc_i, oe_ram_i, oe_ir_i, oe_alu_i, oe_a_i}));

endmodule

// File: microcode_rom.sv
`timescale 1ns/1ps

module microcode_rom import cpu_pkg::*; (
    input  logic [OPCODE_WIDTH-1:0] opcode_i,
    input  logic [STEP_WIDTH-1:0]   step_i,
    output logic                    load_a_o,
    output logic                    load_b_o,
    output logic                    load_o_o,
    output logic                    load_mar_o,
    output logic                    load_ram_o,
    output logic                    load_pc_o,
    output logic                    load_flags_o,
    output logic                    load_sets_z_o,
    output logic                    oe_ram_o,
    output logic                    oe_ir_o,
    output logic                    oe_alu_o,
    output logic                    oe_a_o,
    output logic                    alu_op_o,
    output logic                    last_step_o,
    output logic                    check_zero_o,
    output logic                    check_carry_o,
    output logic                    halt_o
);

    always_comb begin
        load_a_o = 1'b0;  load_b_o = 1'b0;
        load_o_o = 1'b0;  load_mar_o = 1'b0;
        load_ram_o = 1'b0;  load_pc_o = 1'b0;
        load_flags_o = 1'b0;  load_sets_z_o = 1'b0;
        oe_ram_o = 1'b0;  oe_ir_o = 1'b0;
        oe_alu_o = 1'b0;  oe_a_o = 1'b0;
        alu_op_o = ALU_ADD;
        check_zero_o = 1'b0;  check_carry_o = 1'b0;
        halt_o = 1'b0;
        last_step_o = 1'b1;  // Unlisted steps end as a NOP

        case (opcode_i)
            OP_LDA, OP_STA, OP_ADD, OP_SUB: begin
                alu_op_o = (opcode_i == OP_SUB) ? ALU_SUB : ALU_ADD;
                case (step_i)
                    3'd0: begin oe_ir_o = 1'b1; last_step_o = 1'b0; end  // Operand address
                    3'd1: begin
                        oe_ir_o = 1'b1;
                        load_mar_o = 1'b1;
                        last_step_o = 1'b0;
                    end
                    3'd2: begin  // Data onto the bus, or A for a store
                        oe_ram_o = (opcode_i != OP_STA);
                        oe_a_o = (opcode_i == OP_STA);
                        last_step_o = 1'b0;
                    end
                    3'd3: begin
                        oe_ram_o = (opcode_i != OP_STA);
                        oe_a_o = (opcode_i == OP_STA);
                        load_ram_o = (opcode_i == OP_STA);
                        load_a_o = (opcode_i == OP_LDA);
                        load_flags_o = (opcode_i == OP_LDA);
                        load_sets_z_o = (opcode_i == OP_LDA);
                        load_b_o = (opcode_i == OP_ADD) || (opcode_i == OP_SUB);
                        last_step_o = (opcode_i == OP_LDA) || (opcode_i == OP_STA);
                    end
                    3'd4: last_step_o = 1'b0;  // ALU registers A op new B
                    3'd5: begin  // Result and its flags ready together
                        oe_alu_o = 1'b1;
                        load_a_o = 1'b1;
                        load_flags_o = 1'b1;
                    end
                    default: ;
                endcase
            end
            OP_LDI, OP_JMP, OP_JC, OP_JZ: begin
                oe_ir_o = (step_i < 3'd2);
                if (step_i == 3'd0) last_step_o = 1'b0;
                if (step_i == 3'd1) begin
                    load_a_o = (opcode_i == OP_LDI);
                    load_flags_o = (opcode_i == OP_LDI);
                    load_sets_z_o = (opcode_i == OP_LDI);
                    load_pc_o = (opcode_i != OP_LDI);
                    check_carry_o = (opcode_i == OP_JC);
                    check_zero_o = (opcode_i == OP_JZ);
                end
            end
            OP_OUTA: begin
                oe_a_o = (step_i < 3'd2);
                load_o_o = (step_i == 3'd1);
                last_step_o = (step_i != 3'd0);
            end
            OP_HLT: begin
                halt_o = (step_i == 3'd1);  // First step lets the bus settle
                last_step_o = (step_i != 3'd0);
            end
            OP_NOP: ;
            default: ;  // Unused opcodes run as NOP
        endcase
    end

endmodule

// File: cpu_sequencer.sv
`timescale 1ns/1ps

module cpu_sequencer import cpu_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [OPCODE_WIDTH-1:0] opcode_i,
    input  logic                    zero_i,
    input  logic                    carry_i,
    input  logic                    load_a_i,
    input  logic                    load_b_i,
    input  logic                    load_o_i,
    input  logic                    load_mar_i,
    input  logic                    load_ram_i,
    input  logic                    load_pc_i,
    input  logic                    load_flags_i,
    input  logic                    load_sets_z_i,
    input  logic                    oe_ram_i,
    input  logic                    oe_ir_i,
    input  logic                    oe_alu_i,
    input  logic                    oe_a_i,
    input  logic                    alu_op_i,
    input  logic                    last_step_i,
    input  logic                    check_zero_i,
    input  logic                    check_carry_i,
    input  logic                    halt_i,
    output logic [STEP_WIDTH-1:0]   step_o,
    output logic                    load_a_o,
    output logic                    load_b_o,
    output logic                    load_o_o,
    output logic                    load_ir_o,
    output logic                    load_mar_o,
    output logic                    load_ram_o,
    output logic                    load_pc_o,
    output logic                    pc_enable_o,
    output logic                    load_flags_o,
    output logic                    load_sets_z_o,
    output logic                    oe_pc_o,
    output logic                    oe_ram_o,
    output logic                    oe_ir_o,
    output logic                    oe_alu_o,
    output logic                    oe_a_o,
    output logic                    alu_op_o,
    output logic                    halted_o
);

    logic [2:0]            state_q, next_state;
    logic [STEP_WIDTH-1:0] step_q, next_step;
    logic                  jump_fail;  // Checked flag is clear

    assign jump_fail = (check_zero_i && !zero_i) || (check_carry_i && !carry_i);
    assign step_o    = step_q;
    assign halted_o  = (state_q == ST_HALT);

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= ST_RESET;
            step_q  <= '0;
        end else begin
            state_q <= next_state;
            step_q  <= next_step;
        end
    end

    always_comb begin
        next_state = state_q;
        next_step = step_q;
        load_a_o = 1'b0;  load_b_o = 1'b0;  load_o_o = 1'b0;
        load_ir_o = 1'b0;  load_mar_o = 1'b0;  load_ram_o = 1'b0;
        load_pc_o = 1'b0;  pc_enable_o = 1'b0;
        load_flags_o = 1'b0;  load_sets_z_o = 1'b0;
        oe_pc_o = 1'b0;  oe_ram_o = 1'b0;  oe_ir_o = 1'b0;
        oe_alu_o = 1'b0;  oe_a_o = 1'b0;  alu_op_o = ALU_ADD;
        case (state_q)
            ST_RESET:    next_state = ST_FETCH_0;  // Quiet cycle after reset
            ST_FETCH_0: begin oe_pc_o = 1'b1; next_state = ST_FETCH_1; end
            ST_FETCH_1: begin  // PC into MAR
                oe_pc_o = 1'b1;
                load_mar_o = 1'b1;
                next_state = ST_DECODE_0;
            end
            ST_DECODE_0: begin oe_ram_o = 1'b1; next_state = ST_DECODE_1; end
            ST_DECODE_1: begin  // Instruction into IR, PC advances
                oe_ram_o = 1'b1;
                load_ir_o = 1'b1;
                pc_enable_o = 1'b1;
                next_state = ST_WAIT;
            end
            ST_WAIT:     next_state = ST_EXECUTE;
            ST_EXECUTE: begin
                load_a_o = load_a_i;  load_b_o = load_b_i;  load_o_o = load_o_i;
                load_mar_o = load_mar_i;  load_ram_o = load_ram_i;
                load_pc_o = load_pc_i && !jump_fail;  // Untaken jump keeps PC
                load_flags_o = load_flags_i;  load_sets_z_o = load_sets_z_i;
                oe_ram_o = oe_ram_i;  oe_ir_o = oe_ir_i;
                oe_alu_o = oe_alu_i;  oe_a_o = oe_a_i;  alu_op_o = alu_op_i;
                if (halt_i) begin
                    next_state = ST_HALT;
                    next_step = '0;
                end else if (last_step_i) begin
                    next_state = ST_FETCH_0;
                    next_step = '0;
                end else begin
                    next_step = step_q + 1'b1;
                end
            end
            default: ;  // ST_HALT holds with all strobes low
        endcase
    end

    // Microcode always ends before the step counter would wrap
    assert property (@(posedge clk) disable iff (reset)
        (state_q == ST_EXECUTE && step_q == '1) |-> (last_step_i || halt_i));

    // Only a decoded HLT can stop the machine
    assert property (@(posedge clk) disable iff (reset)
        (state_q == ST_EXECUTE && next_state == ST_HALT) |-> (opcode_i == OP_HLT));

endmodule

// File: computer.sv
`timescale 1ns/1ps

module computer import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    output logic [DATA_WIDTH-1:0] out_o,
    output logic                  out_strobe_o,
    output logic                  zero_o,
    output logic                  carry_o,
    output logic                  halted_o
);

    logic [OPCODE_WIDTH-1:0] opcode;
    logic [STEP_WIDTH-1:0]   step;
    logic [ADDR_WIDTH-1:0]   pc, bus_pc;
    // Raw microcode fields
    logic rom_load_a, rom_load_b, rom_load_o, rom_load_mar, rom_load_ram, rom_load_pc;
    logic rom_load_flags, rom_load_sets_z, rom_oe_ram, rom_oe_ir, rom_oe_alu, rom_oe_a;
    logic rom_alu_op, rom_last_step, rom_check_zero, rom_check_carry, rom_halt;
    // Qualified strobes
    logic load_a, load_b, load_o, load_ir, load_mar, load_ram, load_pc, pc_enable;
    logic load_flags, load_sets_z, oe_pc, oe_ram, oe_ir, oe_alu, oe_a, alu_op;

    cpu_sequencer u_sequencer (
        .clk (clk), .reset (reset), .opcode_i (opcode),
        .zero_i (zero_o), .carry_i (carry_o),
        .load_a_i (rom_load_a), .load_b_i (rom_load_b), .load_o_i (rom_load_o),
        .load_mar_i (rom_load_mar), .load_ram_i (rom_load_ram), .load_pc_i (rom_load_pc),
        .load_flags_i (rom_load_flags), .load_sets_z_i (rom_load_sets_z),
        .oe_ram_i (rom_oe_ram), .oe_ir_i (rom_oe_ir), .oe_alu_i (rom_oe_alu),
        .oe_a_i (rom_oe_a), .alu_op_i (rom_alu_op), .last_step_i (rom_last_step),
        .check_zero_i (rom_check_zero), .check_carry_i (rom_check_carry),
        .halt_i (rom_halt), .step_o (step),
        .load_a_o (load_a), .load_b_o (load_b), .load_o_o (load_o), .load_ir_o (load_ir),
        .load_mar_o (load_mar), .load_ram_o (load_ram), .load_pc_o (load_pc),
        .pc_enable_o (pc_enable), .load_flags_o (load_flags), .load_sets_z_o (load_sets_z),
        .oe_pc_o (oe_pc), .oe_ram_o (oe_ram), .oe_ir_o (oe_ir), .oe_alu_o (oe_alu),
        .oe_a_o (oe_a), .alu_op_o (alu_op), .halted_o (halted_o)
    );

    microcode_rom u_rom (
        .opcode_i (opcode), .step_i (step),
        .load_a_o (rom_load_a), .load_b_o (rom_load_b), .load_o_o (rom_load_o),
        .load_mar_o (rom_load_mar), .load_ram_o (rom_load_ram), .load_pc_o (rom_load_pc),
        .load_flags_o (rom_load_flags), .load_sets_z_o (rom_load_sets_z),
        .oe_ram_o (rom_oe_ram), .oe_ir_o (rom_oe_ir), .oe_alu_o (rom_oe_alu),
        .oe_a_o (rom_oe_a), .alu_op_o (rom_alu_op), .last_step_o (rom_last_step),
        .check_zero_o (rom_check_zero), .check_carry_o (rom_check_carry),
        .halt_o (rom_halt)
    );

    program_counter u_pc (
        .clk (clk), .reset (reset), .load_i (load_pc), .enable_i (pc_enable),
        .count_i (bus_pc), .count_o (pc)
    );

    datapath u_datapath (
        .clk (clk), .reset (reset),
        .load_a_i (load_a), .load_b_i (load_b), .load_o_i (load_o), .load_ir_i (load_ir),
        .load_mar_i (load_mar), .load_ram_i (load_ram), .load_flags_i (load_flags),
        .load_sets_z_i (load_sets_z), .oe_pc_i (oe_pc), .oe_ram_i (oe_ram),
        .oe_ir_i (oe_ir), .oe_alu_i (oe_alu), .oe_a_i (oe_a), .alu_op_i (alu_op),
        .pc_i (pc), .bus_pc_o (bus_pc), .opcode_o (opcode),
        .zero_o (zero_o), .carry_o (carry_o),
        .out_o (out_o), .out_strobe_o (out_strobe_o)
    );

endmodule

// File: tb_computer.sv
`timescale 1ns/1ps

module tb_computer import cpu_pkg::*; ();

    logic                  clk;
    logic                  reset;
    logic [DATA_WIDTH-1:0] out;
    logic                  out_strobe;
    logic                  zero;
    logic                  carry;
    logic                  halted;

    logic [DATA_WIDTH-1:0] image [RAM_DEPTH];  // Own copy of the program image
    logic [DATA_WIDTH-1:0] exp_out [$];         // Expected OUTA values in program order
    logic                  exp_zero [$];
    logic                  exp_carry [$];

    int total_cycles  = 0;   // Predicted cycles from reset release to halt
    int limit_cycles  = 0;
    int errors        = 0;
    int checks        = 0;
    int cycle_count   = 0;
    int pulse_count   = 0;
    int pulses_halt   = 0;   // Pulses seen when halted_o rose
    int halt_cycle    = -1;
    bit halt_seen     = 1'b0;
    logic prev_strobe = 1'b0;

    computer dut (
        .clk          (clk),
        .reset        (reset),
        .out_o        (out),
        .out_strobe_o (out_strobe),
        .zero_o       (zero),
        .carry_o      (carry),
        .halted_o     (halted)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;  // 8 ns period

    task automatic check_value(input string what, input int got, input int expected);
        checks++;
        if (got != expected) begin
            errors++;
            $display("mismatch at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
        end
    endtask

    task automatic check_idle(input string when);
        check_value({"out_o ", when}, int'(out), 0);
        check_value({"out_strobe_o ", when}, int'(out_strobe), 0);
        check_value({"zero_o ", when}, int'(zero), 0);
        check_value({"carry_o ", when}, int'(carry), 0);
        check_value({"halted_o ", when}, int'(halted), 0);
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("test %s: %s", name, (errors == errors_before) ? "ok" : "FAILED");
    endtask

    // Instruction-level model of the program; fills the expected queues
    function automatic int predict_run();
        logic [DATA_WIDTH-1:0] mem [RAM_DEPTH];
        instr_word_u           word;
        logic [ADDR_WIDTH-1:0] pc;
        logic [DATA_WIDTH-1:0] a;
        logic [DATA_WIDTH-1:0] b;
        logic [DATA_WIDTH:0]   sum;
        logic                  z;
        logic                  c;
        logic                  done;
        int                    cycles;
        int                    steps;
        int                    count;
        for (int i = 0; i < RAM_DEPTH; i++) mem[i] = image[i];
        pc = '0;
        a = '0;
        b = '0;
        z = 1'b0;
        c = 1'b0;
        done = 1'b0;
        cycles = 0;
        count = 0;
        while (!done && count < 256) begin  // Bounded in case the image never halts
            word.data = mem[pc];
            pc = pc + 1'b1;
            count++;
            sum = {1'b0, a} + {1'b0, b};  // ALU adds A and B on every non-SUB cycle
            case (word.instr.opcode)
                OP_LDA: begin
                    c = sum[DATA_WIDTH];  // Loads still take carry from the ALU
                    a = mem[word.instr.operand];
                    z = (a == '0);
                    steps = 4;
                end
                OP_ADD, OP_SUB: begin
                    b = mem[word.instr.operand];
                    if (word.instr.opcode == OP_SUB) begin
                        c = (a >= b);  // No borrow when A is at least B
                        a = a - b;
                    end else begin
                        sum = {1'b0, a} + {1'b0, b};
                        a = sum[DATA_WIDTH-1:0];
                        c = sum[DATA_WIDTH];
                    end
                    z = (a == '0);
                    steps = 6;
                end
                OP_STA: begin
                    mem[word.instr.operand] = a;
                    steps = 4;
                end
                OP_LDI: begin
                    c = sum[DATA_WIDTH];
                    a = {{(DATA_WIDTH-OPERAND_WIDTH){1'b0}}, word.instr.operand};
                    z = (a == '0);
                    steps = 2;
                end
                OP_JMP, OP_JC, OP_JZ: begin
                    if (word.instr.opcode == OP_JMP ||
                        (word.instr.opcode == OP_JC && c) ||
                        (word.instr.opcode == OP_JZ && z)) begin
                        pc = word.instr.operand;
                    end
                    steps = 2;  // Same cost taken or not
                end
                OP_OUTA: begin
                    exp_out.push_back(a);
                    exp_zero.push_back(z);
                    exp_carry.push_back(c);
                    steps = 2;
                end
                OP_HLT: begin
                    done = 1'b1;
                    steps = 2;
                end
                default: steps = 1;  // NOP and unused opcodes
            endcase
            cycles += 5 + steps;  // Fetch, decode and wait come first
        end
        return cycles;
    endfunction

    // Compares each output pulse against the next expected entry
    always @(posedge clk) begin
        if (!reset) begin
            cycle_count++;
            if (out_strobe) begin
                if (prev_strobe) begin
                    errors++;
                    $display("Error at %0t ns: output strobe high for more than one cycle", $time);
                end
                if (pulse_count < exp_out.size()) begin
                    check_value("out_o", int'(out), int'(exp_out[pulse_count]));
                    check_value("zero_o at output", int'(zero), int'(exp_zero[pulse_count]));
                    check_value("carry_o at output", int'(carry), int'(exp_carry[pulse_count]));
                end else begin
                    errors++;
                    $display("Error at %0t ns: more output pulses than the %0d expected",
                             $time, exp_out.size());
                end
                pulse_count++;
            end
            prev_strobe = out_strobe;
            if (halted && !halt_seen) begin
                halt_seen   = 1'b1;
                halt_cycle  = cycle_count - 1;  // Sampled one edge late
                pulses_halt = pulse_count;
            end
        end
    end

    // Watchdog at twice the predicted run plus margin
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Error: the computer never halted within %0d cycles", limit_cycles);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        int                    errors_before;
        logic [DATA_WIDTH-1:0] held_out;
        reset = 1'b1;
        $readmemh(PROGRAM_FILE, image);
        total_cycles = predict_run();
        limit_cycles = 2 * total_cycles + 100;
        $display("reference: %0d outputs, halt after %0d cycles", exp_out.size(), total_cycles);

        errors_before = errors;
        repeat (8) begin
            @(negedge clk);
            check_idle("in reset");
        end
        reset = 1'b0;
        @(negedge clk);
        check_idle("after reset release");  // Quiet ST_RESET cycle
        report_test("reset values", errors_before);

        errors_before = errors;
        wait (halt_seen);
        report_test("output values and flags", errors_before);

        errors_before = errors;
        check_value("pulse count", pulses_halt, exp_out.size());
        report_test("pulse count", errors_before);

        errors_before = errors;
        check_value("halt cycle", halt_cycle, total_cycles + 1);
        held_out = out;
        repeat (50) begin
            @(negedge clk);
            check_value("out_strobe_o after halt", int'(out_strobe), 0);
            check_value("out_o after halt", int'(out), int'(held_out));
            check_value("halted_o after halt", int'(halted), 1);
        end
        report_test("halt timing and quiet period", errors_before);

        $display("tests: 4, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: program.hex
// One byte per line from address 0, opcode in the high nibble, operand in the low
// Data cells: 0 countdown (starts as unused opcode A), 7 step (a NOP), 14 addend (an OUTA)
A5 // unused opcode runs as NOP, then countdown cell
10 // LDA 0
37 // SUB 7
40 // STA 0
90 // OUTA
87 // JZ 7
61 // JMP 1
0F // step 15, executed as NOP after the loop
50 // LDI 0
90 // OUTA
7F // JC 15, not taken
2E // ADD 14
2E // ADD 14, overflows
7E // JC 14, taken
90 // OUTA, also the addend
F0 // HLT

// File: filelist.f
cpu_pkg.sv
program_counter.sv
alu.sv
ram.sv
datapath.sv
microcode_rom.sv
cpu_sequencer.sv
computer.sv
tb_computer.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench, then scan the log for the fail message
verilator --binary --timing --assert --top-module tb_computer -f filelist.f \
    -o sim_computer > sim.log 2>&1 \
    && ./obj_dir/sim_computer >> sim.log 2>&1 \
    || { echo "Build or simulation failed, see sim.log"; exit 1; }
grep -q "Done: errors found" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
echo "Simulation passed"
